// ==== source/rubiksPkg.sv ====
`default_nettype none

package rubiksPkg;

	// One sticker colour with a bit per channel
	typedef logic [2:0] colourT; // {red, green, blue}

	localparam int unsigned StickerCount = 54;
	localparam int unsigned FaceCount = 6;
	localparam int unsigned FaceSize = 3; // Stickers along one face edge

	// Whole cube with sticker 0 in the lowest group
	typedef colourT [StickerCount-1:0] cubeStateT;

	// Block geometry in pixels
	localparam int unsigned BlockSize = 4;
	localparam int unsigned BlockStride = 5; // One pixel gap between blocks
	localparam int unsigned FaceStride = 16;

	// Top-left corner of the whole net on screen
	localparam int unsigned NetXOffset = 8;
	localparam int unsigned NetYOffset = 8;

	// Face placement in the net, in face units
	// Order is Up, Left, Front, Right, Back, Down
	//
	//        [U]
	//    [L] [F] [R] [B]
	//        [D]
	localparam int unsigned FaceColumn [FaceCount] = '{1, 0, 1, 2, 3, 1};
	localparam int unsigned FaceRow [FaceCount] = '{0, 1, 1, 1, 1, 2};

	// Screen coordinates for a 160x120 frame
	typedef logic [7:0] xCoordT;
	typedef logic [6:0] yCoordT;

	// One block to draw
	typedef struct packed
	{
		xCoordT originX;
		yCoordT originY;
		colourT colour;
	} blockJobT;

	// One pixel write to the frame buffer
	typedef struct packed
	{
		xCoordT x;
		yCoordT y;
		colourT colour;
	} pixelT;

	// Pacing period in clock cycles (about 50000 on the board)
	localparam int unsigned TickPeriod = 4;

endpackage

`default_nettype wire

// ==== source/rateTicker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rateTicker
#(
	parameter int unsigned Period = 4
)
(
	input logic clock,
	input logic rstN,
	output logic tick
);

	localparam int unsigned CountWidth = (Period > 1) ? $clog2(Period) : 1;

	logic [CountWidth-1:0] count;

	// Down counter that pulses on the cycle after it hits zero
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= CountWidth'(Period - 1);
			tick <= 1'b0;
		end
		else
		begin
			tick <= (count == '0);
			if (count == '0)
				count <= CountWidth'(Period - 1); // Reload
			else
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/pipeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeStage
#(
	parameter type payloadT = logic
)
(
	input logic clock,
	input logic rstN,
	input payloadT inData,
	input logic inValid,
	output logic inReady,
	output payloadT outData,
	output logic outValid,
	input logic outReady
);

	// Ready when the slot is free or the held entry leaves this cycle
	assign inReady = !outValid || outReady;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (inValid && inReady)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (inValid && inReady)
			outData <= inData;
	end

endmodule

`default_nettype wire

// ==== source/blockPlotter.sv ====
`timescale 1ns/1ps
`default_nettype none

module blockPlotter
(
	input logic clock,
	input logic rstN,
	input rubiksPkg::blockJobT job,
	input logic jobValid,
	output logic jobReady,
	output rubiksPkg::pixelT pixel,
	output logic pixelValid,
	input logic pixelReady
);

	localparam logic [3:0] LastPixel = 4'(rubiksPkg::BlockSize * rubiksPkg::BlockSize - 1);

	rubiksPkg::blockJobT heldJob;
	logic [3:0] count; // {row, column}
	logic pixelTaken;

	assign jobReady = !pixelValid; // Only take a job when idle
	assign pixelTaken = pixelValid && pixelReady;

	// Column changes fastest
	always_comb
	begin
		pixel.x = heldJob.originX + rubiksPkg::xCoordT'(count[1:0]);
		pixel.y = heldJob.originY + rubiksPkg::yCoordT'(count[3:2]);
		pixel.colour = heldJob.colour;
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			pixelValid <= 1'b0;
			count <= '0;
		end
		else if (jobValid && jobReady)
		begin
			pixelValid <= 1'b1;
			count <= '0;
		end
		else if (pixelTaken)
		begin
			if (count == LastPixel)
				pixelValid <= 1'b0; // Block finished
			else
				count <= count + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (jobValid && jobReady)
			heldJob <= job;
	end

endmodule

`default_nettype wire

// ==== source/stickerSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stickerSequencer
(
	input logic clock,
	input logic rstN,
	input logic go,
	input logic tick,
	input rubiksPkg::cubeStateT cubeState,
	output logic busy,
	output rubiksPkg::blockJobT job,
	output logic jobValid,
	input logic jobReady
);

	typedef enum logic [1:0]
	{
		Idle,
		Drawing,
		Done
	} stateT;

	stateT state;
	rubiksPkg::cubeStateT cube; // Snapshot taken at go
	logic [2:0] face;
	logic [1:0] row;
	logic [1:0] col;
	logic [5:0] sticker;
	logic jobTaken;
	logic lastSticker;
	rubiksPkg::blockJobT nextJob;

	assign jobTaken = jobValid && jobReady;
	assign lastSticker = (face == 3'(rubiksPkg::FaceCount - 1))
		&& (row == 2'(rubiksPkg::FaceSize - 1))
		&& (col == 2'(rubiksPkg::FaceSize - 1));

	assign sticker = 6'((face * rubiksPkg::FaceSize + row) * rubiksPkg::FaceSize + col);

	// Block origin from face slot and position inside the face
	always_comb
	begin
		nextJob.originX = rubiksPkg::xCoordT'(rubiksPkg::NetXOffset
			+ rubiksPkg::FaceColumn[face] * rubiksPkg::FaceStride
			+ col * rubiksPkg::BlockStride);
		nextJob.originY = rubiksPkg::yCoordT'(rubiksPkg::NetYOffset
			+ rubiksPkg::FaceRow[face] * rubiksPkg::FaceStride
			+ row * rubiksPkg::BlockStride);
		nextJob.colour = cube[sticker];
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= Idle;
			busy <= 1'b0;
			jobValid <= 1'b0;
			face <= '0;
			row <= '0;
			col <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (go)
					begin
						state <= Drawing;
						busy <= 1'b1;
						face <= '0;
						row <= '0;
						col <= '0;
					end
				end
				Drawing:
				begin
					if (jobTaken)
					begin
						jobValid <= 1'b0;
						if (lastSticker)
							state <= Done;
						else if (col != 2'(rubiksPkg::FaceSize - 1))
							col <= col + 1'b1;
						else
						begin
							col <= '0;
							if (row != 2'(rubiksPkg::FaceSize - 1))
								row <= row + 1'b1;
							else
							begin
								row <= '0;
								face <= face + 1'b1;
							end
						end
					end
					else if (tick && !jobValid)
						jobValid <= 1'b1; // One job per tick
				end
				Done:
				begin
					// Hold until go is released
					if (!go)
					begin
						state <= Idle;
						busy <= 1'b0;
					end
				end
				default:
					state <= Idle;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clock)
	begin
		if (state == Idle && go)
			cube <= cubeState;
		if (state == Drawing && tick && !jobValid)
			job <= nextJob;
	end

endmodule

`default_nettype wire

// ==== source/cubeRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cubeRenderer
(
	input logic clock,
	input logic rstN,
	input logic go,
	input rubiksPkg::cubeStateT cubeState,
	output logic busy,
	output rubiksPkg::pixelT pixel,
	output logic pixelValid,
	input logic pixelReady
);

	logic tick;

	// Sequencer to job stage
	rubiksPkg::blockJobT seqJob;
	logic seqJobValid;
	logic seqJobReady;

	// Job stage to plotter
	rubiksPkg::blockJobT plotJob;
	logic plotJobValid;
	logic plotJobReady;

	// Plotter to pixel stage
	rubiksPkg::pixelT plotPixel;
	logic plotPixelValid;
	logic plotPixelReady;

	rateTicker #(.Period(rubiksPkg::TickPeriod)) ticker
	(
		.clock(clock),
		.rstN(rstN),
		.tick(tick)
	);

	stickerSequencer sequencer
	(
		.clock(clock),
		.rstN(rstN),
		.go(go),
		.tick(tick),
		.cubeState(cubeState),
		.busy(busy),
		.job(seqJob),
		.jobValid(seqJobValid),
		.jobReady(seqJobReady)
	);

	pipeStage #(.payloadT(rubiksPkg::blockJobT)) jobStage
	(
		.clock(clock),
		.rstN(rstN),
		.inData(seqJob),
		.inValid(seqJobValid),
		.inReady(seqJobReady),
		.outData(plotJob),
		.outValid(plotJobValid),
		.outReady(plotJobReady)
	);

	blockPlotter plotter
	(
		.clock(clock),
		.rstN(rstN),
		.job(plotJob),
		.jobValid(plotJobValid),
		.jobReady(plotJobReady),
		.pixel(plotPixel),
		.pixelValid(plotPixelValid),
		.pixelReady(plotPixelReady)
	);

	pipeStage #(.payloadT(rubiksPkg::pixelT)) pixelStage
	(
		.clock(clock),
		.rstN(rstN),
		.inData(plotPixel),
		.inValid(plotPixelValid),
		.inReady(plotPixelReady),
		.outData(pixel),
		.outValid(pixelValid),
		.outReady(pixelReady)
	);

endmodule

`default_nettype wire

// ==== verif/cubeRendererTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cubeRendererTb;

	// One row of the stimulus table
	typedef struct packed
	{
		logic [1:0] pattern; // 0 one colour, 1 face number, 2 random
		logic randomReady;
		logic changeMid; // Alter cubeState once busy is high
		logic [9:0] pixelCount; // Expected transfers per draw
	} testRowT;

	localparam int TestCount = 4;
	localparam int HoldCycles = 40; // Cycles with go held after the draw
	localparam int TimeoutCycles = TestCount * 54 * 16 * 4 + 1000;

	localparam testRowT TestTable [TestCount] = '{
		'{pattern: 2'd1, randomReady: 1'b0, changeMid: 1'b0, pixelCount: 10'd864},
		'{pattern: 2'd1, randomReady: 1'b1, changeMid: 1'b0, pixelCount: 10'd864},
		'{pattern: 2'd2, randomReady: 1'b1, changeMid: 1'b1, pixelCount: 10'd864},
		'{pattern: 2'd0, randomReady: 1'b0, changeMid: 1'b1, pixelCount: 10'd864}
	};

	// Net layout in face units for Up Left Front Right Back Down
	localparam int FaceCol [6] = '{1, 0, 1, 2, 3, 1};
	localparam int FaceRowPos [6] = '{0, 1, 1, 1, 1, 2};

	logic clock;
	logic rstN;
	logic go;
	rubiksPkg::cubeStateT cubeState;
	logic busy;
	rubiksPkg::pixelT pixel;
	logic pixelValid;
	logic pixelReady;

	logic [31:0] lfsr;
	rubiksPkg::pixelT expected[$];
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;

	cubeRenderer i_dut
	(
		.clock(clock),
		.rstN(rstN),
		.go(go),
		.cubeState(cubeState),
		.busy(busy),
		.pixel(pixel),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady)
	);

	always #5 clock = ~clock;

	// Watchdog
	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			$display("Timeout after %0d cycles, the draws did not complete", cycleCount);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic takeBit();
		lfsr = lfsrStep(lfsr);
		return lfsr[0];
	endfunction

	function automatic rubiksPkg::cubeStateT makeCube(input logic [1:0] pattern);
		rubiksPkg::cubeStateT cube;
		for (int s = 0; s < 54; s++)
		begin
			case (pattern)
				2'd0: cube[s] = 3'h5;
				2'd1: cube[s] = 3'(s / 9); // Colour is the face number
				default:
				begin
					for (int b = 0; b < 3; b++)
						cube[s][b] = takeBit();
				end
			endcase
		end
		return cube;
	endfunction

	// Reference model walks blocks face by face and pixels row by row
	task automatic buildExpected(input rubiksPkg::cubeStateT cube);
		rubiksPkg::pixelT p;
		int baseX;
		int baseY;
		expected.delete();
		for (int face = 0; face < 6; face++)
		begin
			for (int row = 0; row < 3; row++)
			begin
				for (int col = 0; col < 3; col++)
				begin
					baseX = 8 + FaceCol[face] * 16 + col * 5;
					baseY = 8 + FaceRowPos[face] * 16 + row * 5;
					for (int pr = 0; pr < 4; pr++)
					begin
						for (int pc = 0; pc < 4; pc++)
						begin
							p.x = 8'(baseX + pc);
							p.y = 7'(baseY + pr);
							p.colour = cube[face * 9 + row * 3 + col];
							expected.push_back(p);
						end
					end
				end
			end
		end
	endtask

	task automatic checkPixel(input rubiksPkg::pixelT want, input rubiksPkg::pixelT got);
		checkCount++;
		assert (got.x == want.x)
		else
		begin
			$display("Fail pixel.x expected %h got %h", want.x, got.x);
			errorCount++;
		end
		assert (got.y == want.y)
		else
		begin
			$display("Fail pixel.y expected %h got %h", want.y, got.y);
			errorCount++;
		end
		assert (got.colour == want.colour)
		else
		begin
			$display("Fail pixel.colour expected %h got %h", want.colour, got.colour);
			errorCount++;
		end
	endtask

	initial
	begin
		testRowT entry;
		rubiksPkg::cubeStateT captured;
		int received;
		int errorsBefore;
		logic changed;

		clock = 1'b0;
		rstN = 1'b0;
		go = 1'b0;
		pixelReady = 1'b0;
		cubeState = '0;
		lfsr = 32'h52d3_4275;
		repeat (2) @(posedge clock);
		#1 rstN = 1'b1;

		// Nothing may happen before the first go
		repeat (20)
		begin
			@(negedge clock);
			checkCount++;
			assert (!pixelValid && !busy)
			else
			begin
				$display("Output became active while go was still low after reset");
				errorCount++;
			end
		end
		$display("Test idle: %0d errors", errorCount);

		for (int t = 0; t < TestCount; t++)
		begin
			entry = TestTable[t];
			errorsBefore = errorCount;
			received = 0;
			changed = 1'b0;
			captured = makeCube(entry.pattern);
			buildExpected(captured);
			@(posedge clock);
			#1;
			cubeState = captured;
			go = 1'b1;
			pixelReady = entry.randomReady ? takeBit() : 1'b1;
			while (received < int'(entry.pixelCount))
			begin
				@(negedge clock);
				if (pixelValid && pixelReady)
				begin
					checkPixel(expected[received], pixel);
					received++;
				end
				@(posedge clock);
				#1;
				pixelReady = entry.randomReady ? takeBit() : 1'b1;
				if (entry.changeMid && busy && !changed)
				begin
					cubeState = ~captured; // Must not reach the pixels
					changed = 1'b1;
				end
			end

			// Done is held while go stays high
			pixelReady = 1'b1;
			repeat (HoldCycles)
			begin
				@(negedge clock);
				checkCount++;
				assert (busy)
				else
				begin
					$display("busy dropped while go was still high after the draw");
					errorCount++;
				end
				if (pixelValid)
					received++;
			end
			@(posedge clock);
			#1 go = 1'b0;
			while (busy)
			begin
				@(negedge clock);
				if (pixelValid)
					received++;
			end
			checkCount++;
			assert (received == int'(entry.pixelCount))
			else
			begin
				$display("Fail pixel count expected %h got %h", entry.pixelCount, received);
				errorCount++;
			end
			$display("Test %0d: %0d pixels, %0d errors", t, received,
				errorCount - errorsBefore);
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/rubiksPkg.sv
source/rateTicker.sv
source/pipeStage.sv
source/blockPlotter.sv
source/stickerSequencer.sv
source/cubeRenderer.sv
verif/cubeRendererTb.sv

// ==== Makefile ====
# Verilator build and run for the cube renderer testbench

VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= cubeRendererTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
PASS_TEXT ?= TESTS PASSED

SOURCES = $(wildcard source/*.sv verif/*.sv)
BINARY = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  VFLAGS=$(VFLAGS)"
	@echo "  TOP=$(TOP)"
	@echo "  FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR)"

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the run prints the pass message
test: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
